// File: design/id_pkg.sv
`default_nettype none

package id_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam reg_addr_t LINK_REG = 5'd31;    // link destination

    //********************************************************************
    // opcode, funct and regimm rt codes
    //********************************************************************
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_REGIMM  = 6'b000001;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_BLEZ    = 6'b000110;
    localparam logic [5:0] OP_BGTZ    = 6'b000111;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LB      = 6'b100000;
    localparam logic [5:0] OP_LH      = 6'b100001;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_LBU     = 6'b100100;
    localparam logic [5:0] OP_LHU     = 6'b100101;
    localparam logic [5:0] OP_SB      = 6'b101000;
    localparam logic [5:0] OP_SH      = 6'b101001;
    localparam logic [5:0] OP_SW      = 6'b101011;

    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_JALR = 6'b001001;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    localparam logic [4:0] REGIMM_BLTZ   = 5'b00000;
    localparam logic [4:0] REGIMM_BGEZ   = 5'b00001;
    localparam logic [4:0] REGIMM_BLTZAL = 5'b10000;
    localparam logic [4:0] REGIMM_BGEZAL = 5'b10001;

    //********************************************************************
    // one-hot alu operation with add in the top bit
    //********************************************************************
    localparam int ALU_N   = 12;
    localparam int ALU_ADD = 11;
    localparam int ALU_SUB = 10;
    localparam int ALU_SLT = 9;
    localparam int ALU_SLTU = 8;
    localparam int ALU_AND = 7;
    localparam int ALU_NOR = 6;
    localparam int ALU_OR  = 5;
    localparam int ALU_XOR = 4;
    localparam int ALU_SLL = 3;
    localparam int ALU_SRL = 2;
    localparam int ALU_SRA = 1;
    localparam int ALU_LUI = 0;

    typedef logic [ALU_N-1:0] alu_op_t;

    typedef struct packed {
        logic load;
        logic store;
        logic load_sign;    // sign extend byte and half loads
        logic ls_word;
        logic ls_byte;
        logic ls_half;
    } mem_ctl_t;

    typedef enum logic {OPND1_RS, OPND1_SA} opnd1_sel_t;

    typedef enum logic [1:0] {IMM_NONE, IMM_ZERO, IMM_SIGN} imm_ext_t;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BGEZ, BR_BGTZ, BR_BLEZ, BR_BLTZ, BR_J, BR_JR
    } br_kind_t;

    typedef enum logic [1:0] {WDEST_NONE, WDEST_RT, WDEST_RD, WDEST_R31} wdest_sel_t;

endpackage

`default_nettype wire

// File: design/id_ctrl.sv
`default_nettype none

module id_ctrl import id_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       id_valid,
    input  word_t      inst,
    input  logic       if_over,
    input  reg_addr_t  exe_wdest,
    input  reg_addr_t  mem_wdest,
    input  reg_addr_t  wb_wdest,
    input  logic       br_cond,
    output reg_addr_t  rs,
    output reg_addr_t  rt,
    output alu_op_t    alu_op,
    output opnd1_sel_t opnd1_sel,
    output logic       link,
    output imm_ext_t   imm_ext,
    output br_kind_t   br_kind,
    output mem_ctl_t   mem_ctl,
    output wdest_sel_t wdest_sel,
    output logic       rs_wait,
    output logic       rt_wait,
    output logic       id_over,
    output logic       jbr_taken,
    output logic       exe_valid
);

    logic [5:0] op;
    logic [5:0] funct;
    reg_addr_t  rd;
    logic       r_alu;      // special opcode, sa field clear
    logic       shf_sa;     // special opcode, rs field clear

    logic i_addu, i_subu, i_slt, i_sltu, i_and, i_nor, i_or, i_xor;
    logic i_sll, i_srl, i_sra, i_sllv, i_srlv, i_srav, i_jr, i_jalr;
    logic i_addiu, i_slti, i_sltiu, i_andi, i_ori, i_xori, i_lui;
    logic i_beq, i_bne, i_bgez, i_bgtz, i_blez, i_bltz, i_bgezal, i_bltzal;
    logic i_j, i_jal, i_lw, i_lb, i_lbu, i_lh, i_lhu, i_sw, i_sb, i_sh;
    logic i_load, i_store, i_imm_zero, i_imm_sign;
    logic no_rs, no_rt, jbr;

    assign op    = inst[31:26];
    assign rs    = inst[25:21];
    assign rt    = inst[20:16];
    assign rd    = inst[15:11];
    assign funct = inst[5:0];

    //********************************************************************
    // instruction match
    //********************************************************************
    assign r_alu  = (op == OP_SPECIAL) & (inst[10:6] == 5'd0);
    assign shf_sa = (op == OP_SPECIAL) & (rs == 5'd0);

    assign i_addu = r_alu & ((funct == FN_ADDU) | (funct == FN_ADD));    // add treated as addu
    assign i_subu = r_alu & ((funct == FN_SUBU) | (funct == FN_SUB));
    assign i_slt  = r_alu & (funct == FN_SLT);
    assign i_sltu = r_alu & (funct == FN_SLTU);
    assign i_and  = r_alu & (funct == FN_AND);
    assign i_nor  = r_alu & (funct == FN_NOR);
    assign i_or   = r_alu & (funct == FN_OR);
    assign i_xor  = r_alu & (funct == FN_XOR);
    assign i_sllv = r_alu & (funct == FN_SLLV);
    assign i_srlv = r_alu & (funct == FN_SRLV);
    assign i_srav = r_alu & (funct == FN_SRAV);
    assign i_sll  = shf_sa & (funct == FN_SLL);
    assign i_srl  = shf_sa & (funct == FN_SRL);
    assign i_sra  = shf_sa & (funct == FN_SRA);
    assign i_jr   = r_alu & (rt == 5'd0) & (rd == 5'd0) & (funct == FN_JR);
    assign i_jalr = r_alu & (rt == 5'd0) & (funct == FN_JALR);

    assign i_addiu = (op == OP_ADDIU) | (op == OP_ADDI);
    assign i_slti  = (op == OP_SLTI);
    assign i_sltiu = (op == OP_SLTIU);
    assign i_andi  = (op == OP_ANDI);
    assign i_ori   = (op == OP_ORI);
    assign i_xori  = (op == OP_XORI);
    assign i_lui   = (op == OP_LUI) & (rs == 5'd0);

    assign i_beq    = (op == OP_BEQ);
    assign i_bne    = (op == OP_BNE);
    assign i_bgtz   = (op == OP_BGTZ) & (rt == 5'd0);
    assign i_blez   = (op == OP_BLEZ) & (rt == 5'd0);
    assign i_bgez   = (op == OP_REGIMM) & (rt == REGIMM_BGEZ);
    assign i_bltz   = (op == OP_REGIMM) & (rt == REGIMM_BLTZ);
    assign i_bgezal = (op == OP_REGIMM) & (rt == REGIMM_BGEZAL);
    assign i_bltzal = (op == OP_REGIMM) & (rt == REGIMM_BLTZAL);
    assign i_j      = (op == OP_J);
    assign i_jal    = (op == OP_JAL);

    assign i_lw  = (op == OP_LW);
    assign i_lb  = (op == OP_LB);
    assign i_lbu = (op == OP_LBU);
    assign i_lh  = (op == OP_LH);
    assign i_lhu = (op == OP_LHU);
    assign i_sw  = (op == OP_SW);
    assign i_sb  = (op == OP_SB);
    assign i_sh  = (op == OP_SH);

    //********************************************************************
    // control classes
    //********************************************************************
    assign i_load     = i_lw | i_lb | i_lbu | i_lh | i_lhu;
    assign i_store    = i_sw | i_sb | i_sh;
    assign i_imm_zero = i_andi | i_ori | i_xori | i_lui;
    assign i_imm_sign = i_addiu | i_slti | i_sltiu | i_load | i_store;

    assign link      = i_jal | i_jalr | i_bgezal | i_bltzal;
    assign opnd1_sel = (i_sll | i_srl | i_sra) ? OPND1_SA : OPND1_RS;

    always_comb begin
        alu_op           = '0;
        alu_op[ALU_ADD]  = i_addu | i_addiu | i_load | i_store | link;    // links form pc+8
        alu_op[ALU_SUB]  = i_subu;
        alu_op[ALU_SLT]  = i_slt | i_slti;
        alu_op[ALU_SLTU] = i_sltu | i_sltiu;
        alu_op[ALU_AND]  = i_and | i_andi;
        alu_op[ALU_NOR]  = i_nor;
        alu_op[ALU_OR]   = i_or | i_ori;
        alu_op[ALU_XOR]  = i_xor | i_xori;
        alu_op[ALU_SLL]  = i_sll | i_sllv;
        alu_op[ALU_SRL]  = i_srl | i_srlv;
        alu_op[ALU_SRA]  = i_sra | i_srav;
        alu_op[ALU_LUI]  = i_lui;
    end

    always_comb begin
        if (i_imm_zero) imm_ext = IMM_ZERO;
        else if (i_imm_sign) imm_ext = IMM_SIGN;
        else imm_ext = IMM_NONE;
    end

    always_comb begin
        if (i_jr | i_jalr) br_kind = BR_JR;
        else if (i_j | i_jal) br_kind = BR_J;
        else if (i_beq) br_kind = BR_BEQ;
        else if (i_bne) br_kind = BR_BNE;
        else if (i_bgez | i_bgezal) br_kind = BR_BGEZ;
        else if (i_bgtz) br_kind = BR_BGTZ;
        else if (i_blez) br_kind = BR_BLEZ;
        else if (i_bltz | i_bltzal) br_kind = BR_BLTZ;
        else br_kind = BR_NONE;
    end

    always_comb begin
        mem_ctl.load      = i_load;
        mem_ctl.store     = i_store;
        mem_ctl.load_sign = i_lb | i_lh;
        mem_ctl.ls_word   = i_lw | i_sw;
        mem_ctl.ls_byte   = i_lb | i_lbu | i_sb;
        mem_ctl.ls_half   = i_lh | i_lhu | i_sh;
    end

    always_comb begin
        if (i_imm_zero | i_addiu | i_slti | i_sltiu | i_load) begin
            wdest_sel = WDEST_RT;
        end else if (i_jal | i_bgezal | i_bltzal) begin
            wdest_sel = WDEST_R31;
        end else if (i_addu | i_subu | i_slt | i_sltu | i_and | i_nor | i_or | i_xor
                     | i_sll | i_srl | i_sra | i_sllv | i_srlv | i_srav | i_jalr) begin
            wdest_sel = WDEST_RD;
        end else begin
            wdest_sel = WDEST_NONE;
        end
    end

    //********************************************************************
    // read-after-write interlock and stage completion
    //********************************************************************
    assign no_rs = i_j | i_jal;    // rs bits belong to the target field
    assign no_rt = i_addiu | i_slti | i_sltiu | i_imm_zero | i_load
                 | i_bgez | i_bltz | i_bgezal | i_bltzal | i_j | i_jal;

    assign rs_wait = ~no_rs & (rs != 5'd0)
                   & ((rs == exe_wdest) | (rs == mem_wdest) | (rs == wb_wdest));
    assign rt_wait = ~no_rt & (rt != 5'd0)
                   & ((rt == exe_wdest) | (rt == mem_wdest) | (rt == wb_wdest));

    // a jump waits for fetch so the redirect is not lost
    assign jbr       = (br_kind != BR_NONE);
    assign id_over   = id_valid & ~rs_wait & ~rt_wait & (~jbr | if_over);
    assign jbr_taken = br_cond & id_over;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= id_over;    // one pulse per completed instruction
        end
    end

endmodule

`default_nettype wire

// File: design/id_branch_unit.sv
`default_nettype none

module id_branch_unit import id_pkg::*; (
    input  br_kind_t br_kind,
    input  word_t    pc,
    input  word_t    inst,
    input  word_t    rs_value,
    input  word_t    rt_value,
    output logic     br_cond,
    output word_t    jbr_target
);

    word_t bd_pc;          // delay slot pc
    word_t br_offset;
    logic  rs_eq_rt;
    logic  rs_ez;
    logic  rs_ltz;

    assign bd_pc     = pc + word_t'(4);
    assign br_offset = {{(WORD_W-18){inst[15]}}, inst[15:0], 2'b00};
    assign rs_eq_rt  = (rs_value == rt_value);
    assign rs_ez     = (rs_value == '0);
    assign rs_ltz    = rs_value[WORD_W-1];

    always_comb begin
        case (br_kind)
            BR_BEQ:  br_cond = rs_eq_rt;
            BR_BNE:  br_cond = ~rs_eq_rt;
            BR_BGEZ: br_cond = ~rs_ltz;
            BR_BGTZ: br_cond = ~rs_ltz & ~rs_ez;
            BR_BLEZ: br_cond = rs_ltz | rs_ez;
            BR_BLTZ: br_cond = rs_ltz;
            BR_J,
            BR_JR:   br_cond = 1'b1;    // unconditional
            default: br_cond = 1'b0;
        endcase
    end

    always_comb begin
        case (br_kind)
            BR_JR:   jbr_target = rs_value;
            BR_J:    jbr_target = {bd_pc[WORD_W-1:28], inst[25:0], 2'b00};    // region jump
            default: jbr_target = bd_pc + br_offset;
        endcase
    end

endmodule

`default_nettype wire

// File: design/id_operand_path.sv
`default_nettype none

module id_operand_path import id_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       id_over,
    input  alu_op_t    alu_op,
    input  opnd1_sel_t opnd1_sel,
    input  logic       link,
    input  imm_ext_t   imm_ext,
    input  word_t      pc,
    input  word_t      inst,
    input  word_t      rs_value,
    input  word_t      rt_value,
    output alu_op_t    exe_alu_op,
    output word_t      exe_operand1,
    output word_t      exe_operand2,
    output word_t      exe_pc
);

    word_t operand1;
    word_t operand2;

    always_comb begin
        if (link) begin
            operand1 = pc;
        end else if (opnd1_sel == OPND1_SA) begin
            operand1 = {{(WORD_W-5){1'b0}}, inst[10:6]};    // constant shift amount
        end else begin
            operand1 = rs_value;
        end
    end

    always_comb begin
        if (link) begin
            operand2 = word_t'(8);    // return past the delay slot
        end else begin
            case (imm_ext)
                IMM_ZERO: operand2 = {{(WORD_W-16){1'b0}}, inst[15:0]};
                IMM_SIGN: operand2 = {{(WORD_W-16){inst[15]}}, inst[15:0]};
                default:  operand2 = rt_value;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exe_alu_op   <= '0;
            exe_operand1 <= '0;
            exe_operand2 <= '0;
            exe_pc       <= '0;
        end else if (id_over) begin
            exe_alu_op   <= alu_op;
            exe_operand1 <= operand1;
            exe_operand2 <= operand2;
            exe_pc       <= pc;
        end
    end

endmodule

`default_nettype wire

// File: design/id_wb_path.sv
`default_nettype none

module id_wb_path import id_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       id_over,
    input  mem_ctl_t   mem_ctl,
    input  wdest_sel_t wdest_sel,
    input  word_t      inst,
    input  word_t      rt_value,
    output mem_ctl_t   exe_mem_ctl,
    output word_t      exe_store_data,
    output logic       exe_rf_wen,
    output reg_addr_t  exe_rf_wdest
);

    reg_addr_t rf_wdest;
    logic      rf_wen;

    // zero destination when nothing is written keeps the hazard compare clean
    always_comb begin
        case (wdest_sel)
            WDEST_RT:  rf_wdest = inst[20:16];
            WDEST_RD:  rf_wdest = inst[15:11];
            WDEST_R31: rf_wdest = LINK_REG;
            default:   rf_wdest = '0;
        endcase
    end

    assign rf_wen = (wdest_sel != WDEST_NONE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exe_mem_ctl    <= '0;
            exe_store_data <= '0;
            exe_rf_wen     <= 1'b0;
            exe_rf_wdest   <= '0;
        end else if (id_over) begin
            exe_mem_ctl    <= mem_ctl;
            exe_store_data <= rt_value;    // stores always take rt
            exe_rf_wen     <= rf_wen;
            exe_rf_wdest   <= rf_wdest;
        end
    end

endmodule

`default_nettype wire

// File: design/id_stage.sv
`default_nettype none

module id_stage import id_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      id_valid,
    input  word_t     if_id_pc,
    input  word_t     if_id_inst,
    input  word_t     rs_value,
    input  word_t     rt_value,
    input  logic      if_over,
    input  reg_addr_t exe_wdest,
    input  reg_addr_t mem_wdest,
    input  reg_addr_t wb_wdest,
    output reg_addr_t rs,
    output reg_addr_t rt,
    output logic      jbr_taken,
    output word_t     jbr_target,
    output logic      id_over,
    output logic      rs_wait,
    output logic      rt_wait,
    output logic      exe_valid,
    output alu_op_t   exe_alu_op,
    output word_t     exe_operand1,
    output word_t     exe_operand2,
    output mem_ctl_t  exe_mem_ctl,
    output word_t     exe_store_data,
    output logic      exe_rf_wen,
    output reg_addr_t exe_rf_wdest,
    output word_t     exe_pc
);

    alu_op_t    alu_op;
    opnd1_sel_t opnd1_sel;
    logic       link;
    imm_ext_t   imm_ext;
    br_kind_t   br_kind;
    mem_ctl_t   mem_ctl;
    wdest_sel_t wdest_sel;
    logic       br_cond;

    //********************************************************************
    // control
    //********************************************************************
    id_ctrl u_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .id_valid  (id_valid),
        .inst      (if_id_inst),
        .if_over   (if_over),
        .exe_wdest (exe_wdest),
        .mem_wdest (mem_wdest),
        .wb_wdest  (wb_wdest),
        .br_cond   (br_cond),
        .rs        (rs),
        .rt        (rt),
        .alu_op    (alu_op),
        .opnd1_sel (opnd1_sel),
        .link      (link),
        .imm_ext   (imm_ext),
        .br_kind   (br_kind),
        .mem_ctl   (mem_ctl),
        .wdest_sel (wdest_sel),
        .rs_wait   (rs_wait),
        .rt_wait   (rt_wait),
        .id_over   (id_over),
        .jbr_taken (jbr_taken),
        .exe_valid (exe_valid)
    );

    //********************************************************************
    // datapath
    //********************************************************************
    id_branch_unit u_branch (
        .br_kind    (br_kind),
        .pc         (if_id_pc),
        .inst       (if_id_inst),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .br_cond    (br_cond),
        .jbr_target (jbr_target)
    );

    id_operand_path u_operand (
        .clk          (clk),
        .arst_n       (arst_n),
        .id_over      (id_over),
        .alu_op       (alu_op),
        .opnd1_sel    (opnd1_sel),
        .link         (link),
        .imm_ext      (imm_ext),
        .pc           (if_id_pc),
        .inst         (if_id_inst),
        .rs_value     (rs_value),
        .rt_value     (rt_value),
        .exe_alu_op   (exe_alu_op),
        .exe_operand1 (exe_operand1),
        .exe_operand2 (exe_operand2),
        .exe_pc       (exe_pc)
    );

    id_wb_path u_wb (
        .clk            (clk),
        .arst_n         (arst_n),
        .id_over        (id_over),
        .mem_ctl        (mem_ctl),
        .wdest_sel      (wdest_sel),
        .inst           (if_id_inst),
        .rt_value       (rt_value),
        .exe_mem_ctl    (exe_mem_ctl),
        .exe_store_data (exe_store_data),
        .exe_rf_wen     (exe_rf_wen),
        .exe_rf_wdest   (exe_rf_wdest)
    );

endmodule

`default_nettype wire

// File: tests/id_stage_cases.svh
// each row holds pc, inst, rs_val, rt_val, rnd, exe_wd, mem_wd, wb_wd, if_over,
//   alu_op, op1_src, op1, op2_src, op2, mem_ctl, rf_wen, rf_wdest,
//   jbr_taken, jbr_target, id_over, rs_wait, rt_wait
task automatic load_cases;
    // register ALU forms with if_over low
    cases[0]  = '{32'h0040_0000, 32'h0022_1821, 0, 0, 1, 0, 0, 0, 0,
                  12'h800, S_RS, 0, S_RT, 0, 6'b000000, 1, 3, 0, 0, 1, 0, 0};
    cases[1]  = '{32'h0040_0004, 32'h0085_3023, 0, 0, 1, 0, 0, 0, 0,
                  12'h400, S_RS, 0, S_RT, 0, 6'b000000, 1, 6, 0, 0, 1, 0, 0};
    cases[2]  = '{32'h0040_0008, 32'h00E8_4824, 0, 0, 1, 0, 0, 0, 0,
                  12'h080, S_RS, 0, S_RT, 0, 6'b000000, 1, 9, 0, 0, 1, 0, 0};
    cases[3]  = '{32'h0040_000C, 32'h014B_6027, 0, 0, 1, 0, 0, 0, 0,
                  12'h040, S_RS, 0, S_RT, 0, 6'b000000, 1, 12, 0, 0, 1, 0, 0};
    cases[4]  = '{32'h0040_0010, 32'h01AE_7804, 0, 0, 1, 0, 0, 0, 0,
                  12'h008, S_RS, 0, S_RT, 0, 6'b000000, 1, 15, 0, 0, 1, 0, 0};
    cases[5]  = '{32'h0040_0014, 32'h0010_8940, 0, 0, 1, 0, 0, 0, 0,
                  12'h008, S_LIT, 5, S_RT, 0, 6'b000000, 1, 17, 0, 0, 1, 0, 0};
    // immediate forms
    cases[6]  = '{32'h0040_0018, 32'h2422_FFFC, 0, 0, 1, 0, 0, 0, 1,
                  12'h800, S_RS, 0, S_LIT, 32'hFFFF_FFFC, 6'b000000, 1, 2, 0, 0, 1, 0, 0};
    cases[7]  = '{32'h0040_001C, 32'h2864_8001, 0, 0, 1, 0, 0, 0, 1,
                  12'h200, S_RS, 0, S_LIT, 32'hFFFF_8001, 6'b000000, 1, 4, 0, 0, 1, 0, 0};
    cases[8]  = '{32'h0040_0020, 32'h34A6_8765, 0, 0, 1, 0, 0, 0, 1,
                  12'h020, S_RS, 0, S_LIT, 32'h0000_8765, 6'b000000, 1, 6, 0, 0, 1, 0, 0};
    cases[9]  = '{32'h0040_0024, 32'h3C07_BEEF, 0, 0, 1, 0, 0, 0, 1,
                  12'h001, S_RS, 0, S_LIT, 32'h0000_BEEF, 6'b000000, 1, 7, 0, 0, 1, 0, 0};
    // loads and a byte store
    cases[10] = '{32'h0040_0028, 32'h8D09_0010, 0, 0, 1, 0, 0, 0, 1,
                  12'h800, S_RS, 0, S_LIT, 32'h10, 6'b100100, 1, 9, 0, 0, 1, 0, 0};
    cases[11] = '{32'h0040_002C, 32'h814B_FFFF, 0, 0, 1, 0, 0, 0, 1,
                  12'h800, S_RS, 0, S_LIT, 32'hFFFF_FFFF, 6'b101010, 1, 11, 0, 0, 1, 0, 0};
    cases[12] = '{32'h0040_0030, 32'h918D_0003, 0, 0, 1, 0, 0, 0, 1,
                  12'h800, S_RS, 0, S_LIT, 32'h3, 6'b100010, 1, 13, 0, 0, 1, 0, 0};
    cases[13] = '{32'h0040_0034, 32'h85CF_FFFE, 0, 0, 1, 0, 0, 0, 1,
                  12'h800, S_RS, 0, S_LIT, 32'hFFFF_FFFE, 6'b101001, 1, 15, 0, 0, 1, 0, 0};
    cases[14] = '{32'h0040_0038, 32'hA211_0008, 0, 0, 1, 0, 0, 0, 1,
                  12'h800, S_RS, 0, S_LIT, 32'h8, 6'b010010, 0, 0, 0, 0, 1, 0, 0};
    // conditional branches from pc 0x00400100
    cases[15] = '{32'h0040_0100, 32'h1022_0004, 32'h5, 32'h5, 0, 0, 0, 0, 1,
                  12'h000, S_RS, 0, S_RT, 0, 6'b000000, 0, 0, 1, 32'h0040_0114, 1, 0, 0};
    cases[16] = '{32'h0040_0100, 32'h1422_0004, 32'h7, 32'h7, 0, 0, 0, 0, 1,
                  12'h000, S_RS, 0, S_RT, 0, 6'b000000, 0, 0, 0, 0, 1, 0, 0};
    cases[17] = '{32'h0040_0100, 32'h0461_FFFE, 32'h0, 32'h0, 0, 0, 0, 0, 1,
                  12'h000, S_RS, 0, S_RT, 0, 6'b000000, 0, 0, 1, 32'h0040_00FC, 1, 0, 0};
    cases[18] = '{32'h0040_0100, 32'h1C60_0004, 32'h0, 32'h0, 0, 0, 0, 0, 1,
                  12'h000, S_RS, 0, S_RT, 0, 6'b000000, 0, 0, 0, 0, 1, 0, 0};
    cases[19] = '{32'h0040_0100, 32'h1860_0004, 32'h8000_0000, 32'h0, 0, 0, 0, 0, 1,
                  12'h000, S_RS, 0, S_RT, 0, 6'b000000, 0, 0, 1, 32'h0040_0114, 1, 0, 0};
    cases[20] = '{32'h0040_0100, 32'h0460_0004, 32'h1, 32'h0, 0, 0, 0, 0, 1,
                  12'h000, S_RS, 0, S_RT, 0, 6'b000000, 0, 0, 0, 0, 1, 0, 0};
    cases[21] = '{32'h0040_0100, 32'h0470_0004, 32'hFFFF_FFF0, 32'h0, 0, 0, 0, 0, 1,
                  12'h800, S_LIT, 32'h0040_0100, S_LIT, 32'h8, 6'b000000, 1, 31,
                  1, 32'h0040_0114, 1, 0, 0};
    // jumps with two of them stalled by fetch
    cases[22] = '{32'h3000_0200, 32'h0812_3456, 32'h0, 32'h0, 0, 0, 0, 0, 1,
                  12'h000, S_RS, 0, S_RT, 0, 6'b000000, 0, 0, 1, 32'h3048_D158, 1, 0, 0};
    cases[23] = '{32'h3000_0210, 32'h0812_3456, 32'h0, 32'h0, 0, 0, 0, 0, 0,
                  12'h000, S_RS, 0, S_RT, 0, 6'b000000, 0, 0, 0, 0, 0, 0, 0};
    cases[24] = '{32'h3000_0220, 32'h0C00_0010, 32'h0, 32'h0, 0, 0, 0, 0, 1,
                  12'h800, S_LIT, 32'h3000_0220, S_LIT, 32'h8, 6'b000000, 1, 31,
                  1, 32'h3000_0040, 1, 0, 0};
    cases[25] = '{32'h3000_0300, 32'h00A0_0008, 32'h0040_0800, 32'h0, 0, 0, 0, 0, 1,
                  12'h000, S_RS, 0, S_RT, 0, 6'b000000, 0, 0, 1, 32'h0040_0800, 1, 0, 0};
    cases[26] = '{32'h3000_0400, 32'h00A0_0008, 32'h0040_0800, 32'h0, 0, 0, 0, 0, 0,
                  12'h000, S_RS, 0, S_RT, 0, 6'b000000, 0, 0, 0, 0, 0, 0, 0};
    // interlock against exe, mem and wb destinations
    cases[27] = '{32'h0040_0200, 32'h0022_1821, 32'h11, 32'h22, 0, 1, 0, 0, 1,
                  12'h800, S_RS, 0, S_RT, 0, 6'b000000, 1, 3, 0, 0, 0, 1, 0};
    cases[28] = '{32'h0040_0204, 32'h0022_1821, 32'h11, 32'h22, 0, 0, 2, 0, 1,
                  12'h800, S_RS, 0, S_RT, 0, 6'b000000, 1, 3, 0, 0, 0, 0, 1};
    cases[29] = '{32'h0040_0208, 32'h0022_1821, 32'h11, 32'h22, 0, 0, 0, 1, 1,
                  12'h800, S_RS, 0, S_RT, 0, 6'b000000, 1, 3, 0, 0, 0, 1, 0};
    cases[30] = '{32'h0040_020C, 32'h0002_1821, 0, 0, 1, 0, 0, 0, 1,
                  12'h800, S_RS, 0, S_RT, 0, 6'b000000, 1, 3, 0, 0, 1, 0, 0};
    cases[31] = '{32'h0040_0210, 32'h2422_FFFC, 32'h100, 32'h200, 0, 2, 0, 0, 1,
                  12'h800, S_RS, 0, S_LIT, 32'hFFFF_FFFC, 6'b000000, 1, 2, 0, 0, 1, 0, 0};
endtask

// File: tests/id_stage_tb.sv
`default_nettype none

module id_stage_tb import id_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_CASES = 32;
    localparam logic [1:0] S_LIT = 2'd0;    // operand given in the table
    localparam logic [1:0] S_RS  = 2'd1;
    localparam logic [1:0] S_RT  = 2'd2;

    typedef struct packed {
        word_t      pc;
        word_t      inst;
        word_t      rs_val;
        word_t      rt_val;
        logic       rnd;        // replace rs_val and rt_val with random words
        reg_addr_t  exe_wd;
        reg_addr_t  mem_wd;
        reg_addr_t  wb_wd;
        logic       if_over;
        alu_op_t    alu_op;
        logic [1:0] op1_src;
        word_t      op1;
        logic [1:0] op2_src;
        word_t      op2;
        mem_ctl_t   mem_ctl;
        logic       rf_wen;
        reg_addr_t  rf_wdest;
        logic       jbr_taken;
        word_t      jbr_target;
        logic       id_over;
        logic       rs_wait;
        logic       rt_wait;
    } case_t;

    logic      clk;
    logic      arst_n;
    logic      id_valid;
    logic      if_over;
    word_t     if_id_pc;
    word_t     if_id_inst;
    word_t     rs_value;
    word_t     rt_value;
    reg_addr_t exe_wdest;
    reg_addr_t mem_wdest;
    reg_addr_t wb_wdest;
    reg_addr_t rs;
    reg_addr_t rt;
    logic      jbr_taken;
    word_t     jbr_target;
    logic      id_over;
    logic      rs_wait;
    logic      rt_wait;
    logic      exe_valid;
    alu_op_t   exe_alu_op;
    word_t     exe_operand1;
    word_t     exe_operand2;
    mem_ctl_t  exe_mem_ctl;
    word_t     exe_store_data;
    logic      exe_rf_wen;
    reg_addr_t exe_rf_wdest;
    word_t     exe_pc;

    case_t  cases [N_CASES];
    int     case_idx;
    integer seed;

    id_stage dut (.*);

    always #50 clk = ~clk;    // 100 ns period

    `include "id_stage_cases.svh"

    //**********************************************************************
    // compare tasks
    //**********************************************************************
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input string exp, input string act);
        abort_run($sformatf("CHECK FAILED at %0t ns: case %0d %s expected %s got %s",
                            $time, case_idx, name, exp, act));
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) report_mismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    task automatic check_alu_op(input string name, input alu_op_t exp, input alu_op_t act);
        if (act !== exp) report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic check_mem_ctl(input string name, input mem_ctl_t exp, input mem_ctl_t act);
        if (act !== exp) report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    function automatic word_t pick_operand(input logic [1:0] src, input word_t lit,
                                           input word_t rs_v, input word_t rt_v);
        case (src)
            S_RS:    return rs_v;
            S_RT:    return rt_v;
            default: return lit;
        endcase
    endfunction

    // registered outputs against the instruction last handed on
    task automatic check_exe_outputs(input case_t e);
        check_alu_op("exe_alu_op", e.alu_op, exe_alu_op);
        check_word("exe_operand1",
                   pick_operand(e.op1_src, e.op1, e.rs_val, e.rt_val), exe_operand1);
        check_word("exe_operand2",
                   pick_operand(e.op2_src, e.op2, e.rs_val, e.rt_val), exe_operand2);
        check_mem_ctl("exe_mem_ctl", e.mem_ctl, exe_mem_ctl);
        check_word("exe_store_data", e.rt_val, exe_store_data);
        check_bit("exe_rf_wen", e.rf_wen, exe_rf_wen);
        check_addr("exe_rf_wdest", e.rf_wdest, exe_rf_wdest);
        check_word("exe_pc", e.pc, exe_pc);
    endtask

    //**********************************************************************
    // stimulus
    //**********************************************************************
    initial begin
        case_t c;
        case_t last_c;
        int    waited;
        clk        = 1'b0;
        arst_n     = 1'b0;
        id_valid   = 1'b0;
        if_over    = 1'b0;
        if_id_pc   = '0;
        if_id_inst = '0;
        rs_value   = '0;
        rt_value   = '0;
        exe_wdest  = '0;
        mem_wdest  = '0;
        wb_wdest   = '0;
        seed       = 29;
        case_idx   = -1;
        load_cases();
        repeat (8) @(posedge clk);
        #1 arst_n = 1'b1;

        check_bit("exe_valid", 1'b0, exe_valid);    // reset state
        check_bit("exe_rf_wen", 1'b0, exe_rf_wen);
        check_alu_op("exe_alu_op", '0, exe_alu_op);
        check_word("exe_operand1", '0, exe_operand1);
        check_word("exe_operand2", '0, exe_operand2);
        check_mem_ctl("exe_mem_ctl", '0, exe_mem_ctl);
        check_word("exe_store_data", '0, exe_store_data);
        check_addr("exe_rf_wdest", '0, exe_rf_wdest);
        check_word("exe_pc", '0, exe_pc);
        last_c = '0;

        for (int i = 0; i < N_CASES; i++) begin
            c        = cases[i];
            case_idx = i;
            if (c.rnd) begin
                c.rs_val = $random(seed);
                c.rt_val = $random(seed);
            end
            id_valid   = 1'b1;    // 1 ns after the edge
            if_over    = c.if_over;
            if_id_pc   = c.pc;
            if_id_inst = c.inst;
            rs_value   = c.rs_val;
            rt_value   = c.rt_val;
            exe_wdest  = c.exe_wd;
            mem_wdest  = c.mem_wd;
            wb_wdest   = c.wb_wd;

            @(negedge clk);    // combinational outputs settled
            check_addr("rs", c.inst[25:21], rs);
            check_addr("rt", c.inst[20:16], rt);
            check_bit("rs_wait", c.rs_wait, rs_wait);
            check_bit("rt_wait", c.rt_wait, rt_wait);
            check_bit("id_over", c.id_over, id_over);
            check_bit("jbr_taken", c.jbr_taken, jbr_taken);
            if (c.jbr_taken) check_word("jbr_target", c.jbr_target, jbr_target);

            @(posedge clk);
            #1 id_valid = 1'b0;
            if (c.id_over) begin
                waited = 0;
                while (exe_valid !== 1'b1) begin
                    if (waited == 10) abort_run("exe_valid never rose after decode completed");
                    @(posedge clk);
                    #1 waited++;
                end
                check_exe_outputs(c);
                last_c = c;
            end else begin
                check_bit("exe_valid", 1'b0, exe_valid);    // stalled so nothing handed on
                check_exe_outputs(last_c);
            end
        end

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+tests
design/id_pkg.sv
design/id_ctrl.sv
design/id_branch_unit.sv
design/id_operand_path.sv
design/id_wb_path.sv
design/id_stage.sv
tests/id_stage_tb.sv
